//--- include/periph_bus_defs.svh
// Peripheral bus constants
// Widths of the APB address and data words, the number of register
// peripherals, the page that peripheral 0 owns and the ID word pattern

`ifndef PERIPH_BUS_DEFS_SVH
`define PERIPH_BUS_DEFS_SVH

// APB word widths
`define APB_ADDR_W 32
`define APB_DATA_W 32

// number of identical register peripherals on the bus
`define NUM_PERIPH 4

// every peripheral owns one aligned 4 KB page
`define PAGE_W 12

// page number of peripheral 0, peripheral i sits at BASE_PAGE + i
`define BASE_PAGE 20'h1A100

// upper half of every ID word, the lower half carries the peripheral index
`define PERIPH_ID 16'hA5B0

`endif

//--- rtl/periph_bus_pkg.sv
// Peripheral bus types
// Holds the two views of an APB address word and the index type that
// names one of the register peripherals

`include "periph_bus_defs.svh"

package periph_bus_pkg;

    // page number in the upper bits, byte offset inside the page below
    typedef struct packed {
        logic [`APB_ADDR_W-`PAGE_W-1:0] page;
        logic [`PAGE_W-1:0]             offset;
    } apb_addr_fields_t;

    // the decoder looks at the page, a peripheral only at the offset
    typedef union packed {
        logic [`APB_ADDR_W-1:0] flat;
        apb_addr_fields_t       fields;
    } apb_addr_u;

    // index of the peripheral that a transfer targets
    typedef logic [$clog2(`NUM_PERIPH)-1:0] periph_idx_t;

endpackage

//--- rtl/apb_if.sv
// APB link between the decoder and one register peripheral
// The master side drives the request, the slave side answers with
// ready, read data and error

`timescale 1ns/1ps

`include "periph_bus_defs.svh"

interface apb_if;

    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
    logic                   pwrite;
    logic                   psel;
    logic                   penable;
    logic                   pready;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pslverr;

    modport master (
        output paddr, pwdata, pwrite, psel, penable,
        input  pready, prdata, pslverr
    );

    modport slave (
        input  paddr, pwdata, pwrite, psel, penable,
        output pready, prdata, pslverr
    );

endinterface

//--- rtl/apb_addr_decoder.sv
// APB address decoder
// Finds the page of each transfer, turns it into a peripheral index and
// forwards the request to that peripheral only. Pages outside the mapped
// range clear the hit flag so that the response multiplexer can answer
// with a decode error

`timescale 1ns/1ps

`include "periph_bus_defs.svh"

module apb_addr_decoder
    import periph_bus_pkg::*;
(
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    input  logic                   pwrite,
    input  logic                   psel,
    input  logic                   penable,
    apb_if.master                  periph [`NUM_PERIPH-1:0],
    output periph_idx_t            sel_idx,
    output logic                   sel_hit
);

    apb_addr_u                      addr;
    logic [`APB_ADDR_W-`PAGE_W-1:0] page_diff;

    assign addr.flat = paddr;

    // pages below the base wrap around to a large difference and miss
    assign page_diff = addr.fields.page - `BASE_PAGE;
    assign sel_hit   = (page_diff < `NUM_PERIPH);
    assign sel_idx   = page_diff[$bits(periph_idx_t)-1:0];

    // every link sees the request, only the selected one sees psel
    for (genvar i = 0; i < `NUM_PERIPH; i++) begin : g_fanout
        assign periph[i].paddr   = paddr;
        assign periph[i].pwdata  = pwdata;
        assign periph[i].pwrite  = pwrite;
        assign periph[i].penable = penable;
        assign periph[i].psel    = psel && sel_hit && (sel_idx == periph_idx_t'(i));
    end

endmodule

//--- rtl/apb_reg_periph.sv
// APB register peripheral
// Four word registers: ID, scratch, control and a count of accepted
// writes. Every access inserts one wait state. Writes to the read-only
// words and accesses past the last register end with pslverr and
// leave the registers untouched

`timescale 1ns/1ps

`include "periph_bus_defs.svh"

module apb_reg_periph
    import periph_bus_pkg::*;
#(
    parameter int PERIPH_IDX = 0
) (
    input logic  clk_i,
    input logic  rst_n,
    apb_if.slave bus
);

    localparam logic [1:0] REG_ID      = 2'd0;
    localparam logic [1:0] REG_SCRATCH = 2'd1;
    localparam logic [1:0] REG_CTRL    = 2'd2;
    localparam logic [1:0] REG_WR_CNT  = 2'd3;

    apb_addr_u              addr;
    logic [1:0]             reg_sel;
    logic                   in_range;
    logic                   access;
    logic                   complete;
    logic                   err;
    logic                   wait_q;
    logic [`APB_DATA_W-1:0] scratch_q;
    logic [`APB_DATA_W-1:0] ctrl_q;
    logic [`APB_DATA_W-1:0] wr_cnt_q;
    logic [`APB_DATA_W-1:0] rdata;

    assign addr.flat = bus.paddr;
    assign reg_sel   = addr.fields.offset[3:2];
    assign in_range  = (addr.fields.offset < `PAGE_W'('h10));

    assign access   = bus.psel && bus.penable;
    assign complete = access && wait_q;

    // ID and counter words are read-only
    assign err = !in_range ||
                 (bus.pwrite && ((reg_sel == REG_ID) || (reg_sel == REG_WR_CNT)));

    // set in the first access cycle, cleared again when the transfer completes
    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= access && !wait_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            scratch_q <= '0;
            ctrl_q    <= '0;
            wr_cnt_q  <= '0;
        end else if (complete && bus.pwrite && !err) begin
            if (reg_sel == REG_SCRATCH) begin
                scratch_q <= bus.pwdata;
            end
            if (reg_sel == REG_CTRL) begin
                ctrl_q <= bus.pwdata;
            end
            wr_cnt_q <= wr_cnt_q + 1'b1;
        end
    end

    always_comb begin
        case (reg_sel)
            REG_ID:      rdata = {`PERIPH_ID, 16'(PERIPH_IDX)};
            REG_SCRATCH: rdata = scratch_q;
            REG_CTRL:    rdata = ctrl_q;
            default:     rdata = wr_cnt_q;
        endcase
    end

    assign bus.pready  = complete;
    assign bus.pslverr = complete && err;
    assign bus.prdata  = (complete && !bus.pwrite && !err) ? rdata : '0;

endmodule

//--- rtl/apb_resp_mux.sv
// APB response multiplexer
// Passes the response of the selected peripheral back to the requester.
// For an unmapped page it completes the transfer itself with an error
// in the first access cycle

`timescale 1ns/1ps

`include "periph_bus_defs.svh"

module apb_resp_mux
    import periph_bus_pkg::*;
(
    apb_if.slave                   periph [`NUM_PERIPH-1:0],
    input  periph_idx_t            sel_idx,
    input  logic                   sel_hit,
    input  logic                   psel,
    input  logic                   penable,
    output logic                   pready,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pslverr
);

    logic                   rdy   [`NUM_PERIPH];
    logic [`APB_DATA_W-1:0] rdata [`NUM_PERIPH];
    logic                   err   [`NUM_PERIPH];

    // responses of all links, picked by sel_idx below
    for (genvar i = 0; i < `NUM_PERIPH; i++) begin : g_collect
        assign rdy[i]   = periph[i].pready;
        assign rdata[i] = periph[i].prdata;
        assign err[i]   = periph[i].pslverr;
    end

    always_comb begin
        if (sel_hit) begin
            pready  = rdy[sel_idx];
            prdata  = rdata[sel_idx];
            pslverr = err[sel_idx];
        end else begin
            pready  = psel && penable;
            prdata  = '0;
            pslverr = psel && penable;
        end
    end

endmodule

//--- rtl/periph_bus_top.sv
// Peripheral bus subsystem
// One APB requester enters here. The decoder fans each transfer out to
// one of NUM_PERIPH register peripherals on their own 4 KB pages, and the
// response multiplexer returns the answer or a decode error

`timescale 1ns/1ps

`include "periph_bus_defs.svh"

module periph_bus_top
    import periph_bus_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n,
    input  logic [`APB_ADDR_W-1:0] paddr,
    input  logic [`APB_DATA_W-1:0] pwdata,
    input  logic                   pwrite,
    input  logic                   psel,
    input  logic                   penable,
    output logic                   pready,
    output logic [`APB_DATA_W-1:0] prdata,
    output logic                   pslverr
);

    periph_idx_t sel_idx;
    logic        sel_hit;

    // one link per peripheral
    apb_if periph_bus [`NUM_PERIPH-1:0] ();

    apb_addr_decoder i_decoder (
        .paddr   ( paddr      ),
        .pwdata  ( pwdata     ),
        .pwrite  ( pwrite     ),
        .psel    ( psel       ),
        .penable ( penable    ),
        .periph  ( periph_bus ),
        .sel_idx ( sel_idx    ),
        .sel_hit ( sel_hit    )
    );

    for (genvar i = 0; i < `NUM_PERIPH; i++) begin : g_periph
        apb_reg_periph #(
            .PERIPH_IDX ( i )
        ) i_periph (
            .clk_i ( clk_i         ),
            .rst_n ( rst_n         ),
            .bus   ( periph_bus[i] )
        );
    end

    apb_resp_mux i_resp_mux (
        .periph  ( periph_bus ),
        .sel_idx ( sel_idx    ),
        .sel_hit ( sel_hit    ),
        .psel    ( psel       ),
        .penable ( penable    ),
        .pready  ( pready     ),
        .prdata  ( prdata     ),
        .pslverr ( pslverr    )
    );

endmodule

//--- tb/tb_periph_bus.sv
// Testbench for the peripheral bus subsystem
// Replays the transfers of the golden file as APB requester, one at a
// time, and checks the read data, the error flag and the number of
// cycles from setup to completion of every transfer

`timescale 1ns/1ps

`include "periph_bus_defs.svh"

module tb_periph_bus;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 22;
    localparam int NUM_COLS     = 6;
    localparam int TIMEOUT      = 10;

    logic                   clk_i;
    logic                   rst_n;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
    logic                   pwrite;
    logic                   psel;
    logic                   penable;
    logic                   pready;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pslverr;

    // six words per transfer, in the column order of the golden file
    logic [31:0] golden [NUM_TESTS*NUM_COLS];

    periph_bus_top i_dut (
        .clk_i   ( clk_i   ),
        .rst_n   ( rst_n   ),
        .paddr   ( paddr   ),
        .pwdata  ( pwdata  ),
        .pwrite  ( pwrite  ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pready  ( pready  ),
        .prdata  ( prdata  ),
        .pslverr ( pslverr )
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    task automatic check_rdata(input string name, input logic [`APB_DATA_W-1:0] expected,
                               input logic [`APB_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("error: %s prdata expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_err(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: %s pslverr expected %b actual %b", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "error flag mismatch");
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: %s pready expected %b actual %b", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "ready mismatch");
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("error: %s cycles expected %0d actual %0d", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "transfer length mismatch");
        end
    endtask

    // a mapped page costs setup, one wait and the completing access
    function automatic int expected_cycles(input logic [`APB_ADDR_W-1:0] addr);
        int page_num;
        page_num = int'(addr >> `PAGE_W);
        if (page_num >= int'(`BASE_PAGE) && page_num < int'(`BASE_PAGE) + `NUM_PERIPH) begin
            return 3;
        end
        return 2;
    endfunction

    // one APB transfer, sampled a quarter period after each falling edge
    task automatic run_transfer(input string name, input logic wr,
                                input logic [`APB_ADDR_W-1:0] addr,
                                input logic [`APB_DATA_W-1:0] wdata,
                                output logic [`APB_DATA_W-1:0] rdata,
                                output logic err, output int cycles);
        int wait_cnt;
        @(negedge clk_i);
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = wr;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk_i);
        penable  = 1'b1;
        wait_cnt = 0;
        #(CLK_PERIOD/4);
        while (pready !== 1'b1) begin
            if (wait_cnt == TIMEOUT) begin
                $display("%s got no pready within %0d cycles", name, TIMEOUT);
                $display("TEST RESULT: FAIL");
                $fatal(1, "transfer timed out");
            end
            @(negedge clk_i);
            #(CLK_PERIOD/4);
            wait_cnt++;
        end
        rdata  = prdata;
        err    = pslverr;
        cycles = wait_cnt + 2;
        @(negedge clk_i);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin
        logic [`APB_DATA_W-1:0] rdata;
        logic                   err;
        logic                   wr;
        int                     cycles;
        int                     base;
        string                  name;
        clk_i   = 1'b0;
        rst_n   = 1'b0;
        // parked on peripheral 0 so that the reset check sees a peripheral's ready
        paddr   = {`BASE_PAGE, `PAGE_W'(0)};
        pwdata  = '0;
        pwrite  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        $readmemh("tb/periph_bus_golden.mem", golden);

        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n = 1'b1;
        #(CLK_PERIOD/4);
        check_ready("reset", 1'b0, pready);

        for (int k = 0; k < NUM_TESTS; k++) begin
            base = k * NUM_COLS;
            name = $sformatf("test %0d", golden[base]);
            wr   = golden[base+1][0];
            run_transfer(name, wr, golden[base+2], golden[base+3], rdata, err, cycles);
            check_cycles(name, expected_cycles(golden[base+2]), cycles);
            check_err(name, golden[base+5][0], err);
            if (!wr) begin
                check_rdata(name, golden[base+4], rdata);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- tb/periph_bus_golden.mem
// columns: test number, write flag, address, write data,
// expected read data, expected pslverr
01 0 1A100000 00000000 A5B00000 0
02 0 1A101000 00000000 A5B00001 0
03 0 1A102000 00000000 A5B00002 0
04 0 1A103000 00000000 A5B00003 0
05 1 1A101004 11112222 00000000 0
06 1 1A102004 DEADBEEF 00000000 0
07 0 1A101004 00000000 11112222 0
08 0 1A102004 00000000 DEADBEEF 0
09 1 1A102008 0000C0DE 00000000 0
0A 0 1A102008 00000000 0000C0DE 0
0B 0 1A10200C 00000000 00000002 0
0C 0 1A10100C 00000000 00000001 0
0D 0 1A10000C 00000000 00000000 0
0E 0 1A104000 00000000 00000000 1
0F 1 1A0FF004 12345678 00000000 1
10 1 1A102000 FFFFFFFF 00000000 1
11 1 1A10200C 00000010 00000000 1
12 0 1A102010 00000000 00000000 1
13 1 1A102014 55555555 00000000 1
14 0 1A102000 00000000 A5B00002 0
15 0 1A10200C 00000000 00000002 0
16 0 1A102004 00000000 DEADBEEF 0

//--- tb.f
+incdir+include
rtl/periph_bus_pkg.sv
rtl/apb_if.sv
rtl/apb_addr_decoder.sv
rtl/apb_reg_periph.sv
rtl/apb_resp_mux.sv
rtl/periph_bus_top.sv
tb/tb_periph_bus.sv

//--- Makefile
# Verilator build and run for the peripheral bus testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_periph_bus
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides pass or fail, so the simulator status is not used here
run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
